// File: verification/spif_testdata.txt
// Each entry is 9 hex digits: tag (1), address (3), value (5).
// Tag 1 is a flash byte at a stream offset, 2 a code RAM word, 3 a data RAM word.
1000000A1                               // Divisor 1 with processor held in reset
1001000C0 100200000 100300010           // Destination 0x0010
1004000D0 100500000 100600002           // Three words
100700001                               // Code run of 2-byte words
100800012 100900034                     // 0x1234
100A000AB 100B000CD                     // 0xABCD
100C0000F 100D0000E                     // 0x0F0E
100E000C0 100F00001 101000000           // Destination 0x0100
1011000D0 101200000 101300001           // Two words
101400006                               // Data run of 3-byte words
101500003 1016000FF 1017000FF
101800001 101900023 101A00045
101B000C0 101C00002 101D00003           // Second destination 0x0203
101E000D0 101F00000 102000000           // One word
102100006
102200002 1023000AA 102400055
1025000E0                               // End of boot

// Expected code RAM words
201001234 20110ABCD 201200F0E

// Expected data RAM words
31003FFFF 310112345 32032AA55

// File: sim.f
src/spif_pkg.sv
src/spi_xfer_if.sv
src/boot_wr_if.sv
src/spi_byte_master.sv
src/boot_fetch.sv
src/boot_interp.sv
src/spram.sv
src/mem_port_mux.sv
src/spif_top.sv
verification/flash_model.sv
verification/tb_spif.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := tb_spif
FLIST := sim.f
PASS  := ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// File: verification/tb_spif.sv
// ======================================================================
// Testbench for the boot flash loader. Loads the flash image and the
// expected RAM words from the test data file, then checks boot and RAMs.
// ======================================================================

module tb_spif;

  logic                  clk;
  logic                  arstn;
  spif_pkg::code_addr_t  code_addr;
  spif_pkg::code_word_t  insn;
  logic                  mem_rd;
  logic                  mem_wr;
  spif_pkg::data_addr_t  mem_addr;
  spif_pkg::data_word_t  din;
  spif_pkg::data_word_t  mem_dout;
  logic                  p_hold;
  logic                  p_reset;
  logic                  booting;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  logic [39:0]           hdr;
  logic [2:0]            hdr_cnt;
  logic [35:0]           td [256];            // Tag, address, value
  spif_pkg::code_addr_t  code_exp_addr [$];
  spif_pkg::code_word_t  code_exp_val [$];
  spif_pkg::data_addr_t  data_exp_addr [$];
  spif_pkg::data_word_t  data_exp_val [$];
  logic                  hold_q;
  int                    hold_pulses;

  spif_top u_dut (
    .clk        (clk),       .arstn      (arstn),
    .i_code_addr (code_addr), .o_insn     (insn),
    .i_mem_rd   (mem_rd),    .i_mem_wr   (mem_wr),    .i_mem_addr (mem_addr),
    .i_din      (din),       .o_mem_dout (mem_dout),  .o_p_hold   (p_hold),
    .o_p_reset  (p_reset),   .o_booting  (booting),
    .o_sclk     (sclk),      .o_cs_n     (cs_n),      .o_mosi     (mosi),
    .i_miso     (miso)
  );

  flash_model u_flash (
    .i_sclk (sclk), .i_cs_n (cs_n), .i_mosi (mosi), .o_miso (miso),
    .o_hdr  (hdr),  .o_hdr_cnt (hdr_cnt)
  );

  always #5 clk = ~clk;

  // Boot write pulses seen on hold
  always @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      hold_q      <= 1'b0;
      hold_pulses <= 0;
    end else begin
      hold_q <= p_hold;
      if (p_hold && !hold_q && booting)
        hold_pulses <= hold_pulses + 1;
    end
  end

  // ====================================================================
  // Reporting and compares
  // ====================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic level_is(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("level mismatch");
    end
  endtask

  task automatic flash_byte_is(input string name, input spif_pkg::byte_t got,
                               input spif_pkg::byte_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("flash byte mismatch");
    end
  endtask

  task automatic code_word_is(input string name, input spif_pkg::code_word_t got,
                              input spif_pkg::code_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("code word mismatch");
    end
  endtask

  task automatic data_word_is(input string name, input spif_pkg::data_word_t got,
                              input spif_pkg::data_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("data word mismatch");
    end
  endtask

  task automatic count_is(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      abort_run("count mismatch");
    end
  endtask

  // ====================================================================
  // Stimulus helpers
  // ====================================================================
  task automatic step_clock();
    @(posedge clk);
    #1;                                       // Drive after the edge
  endtask

  task automatic load_testdata();
    logic [35:0] entry;
    for (int n = 0; n < 256; n++) begin
      td[8'(n)] = '0;
      u_flash.put_byte(8'(n), ~8'(n));        // Unused image bytes
    end
    $readmemh("verification/spif_testdata.txt", td);
    for (int n = 0; n < 256; n++) begin
      entry = td[8'(n)];
      case (entry[35:32])
        4'h0: begin
        end
        4'h1: u_flash.put_byte(entry[27:20], entry[7:0]);
        4'h2: begin
          code_exp_addr.push_back(entry[29:20]);
          code_exp_val.push_back(entry[15:0]);
        end
        4'h3: begin
          data_exp_addr.push_back(entry[29:20]);
          data_exp_val.push_back(entry[17:0]);
        end
        default: abort_run("unknown entry tag in the test data file");
      endcase
    end
    if (code_exp_addr.size() == 0 || data_exp_addr.size() == 0)
      abort_run("test data file holds no expected words");
  endtask

  task automatic fetch_insn(input spif_pkg::code_addr_t a, input spif_pkg::code_word_t exp);
    code_addr = a;
    step_clock();
    code_word_is($sformatf("o_insn[%h]", a), insn, exp);
  endtask

  task automatic read_data_word(input spif_pkg::data_addr_t a,
                                input spif_pkg::data_word_t exp);
    mem_addr = a;
    mem_rd   = 1'b1;
    step_clock();
    mem_rd   = 1'b0;
    data_word_is($sformatf("o_mem_dout[%h]", a), mem_dout, exp);
  endtask

  task automatic write_data_word(input spif_pkg::data_addr_t a,
                                 input spif_pkg::data_word_t v);
    mem_addr = a;
    din      = v;
    mem_wr   = 1'b1;
    step_clock();
    mem_wr   = 1'b0;
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    int                    cycles;
    int                    j;
    int                    tmp;
    int                    order [$];
    spif_pkg::data_addr_t  waddr;
    spif_pkg::data_word_t  wval;
    clk       = 1'b0;
    arstn     = 1'b0;
    code_addr = '0;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    mem_addr  = '0;
    din       = '0;
    void'($urandom(57349));
    load_testdata();
    repeat (2) step_clock();
    arstn = 1'b1;
    level_is("o_p_reset", p_reset, 1'b1);
    level_is("o_booting", booting, 1'b1);
    level_is("o_cs_n", cs_n, 1'b1);
    level_is("o_sclk", sclk, 1'b0);
    level_is("o_p_hold", p_hold, 1'b0);

    cycles = 0;
    while (hdr_cnt != 3'd5) begin
      step_clock();
      cycles++;
      if (cycles > 2000)
        abort_run("flash read header not seen within the timeout");
    end
    flash_byte_is("mosi header 0", hdr[39:32], spif_pkg::FAST_READ_CMD);
    flash_byte_is("mosi header 1", hdr[31:24], spif_pkg::BASE_BLOCK);
    flash_byte_is("mosi header 2", hdr[23:16], 8'h00);
    flash_byte_is("mosi header 3", hdr[15:8], 8'h00);
    flash_byte_is("mosi header 4", hdr[7:0], 8'h00);

    cycles = 0;
    while (booting) begin
      step_clock();
      cycles++;
      if (cycles > 20000)
        abort_run("o_booting did not fall within the timeout");
    end
    level_is("o_p_reset", p_reset, 1'b0);
    cycles = 0;
    while (cs_n !== 1'b1) begin
      step_clock();
      cycles++;
      if (cycles > 8)
        abort_run("o_cs_n did not rise after boot");
    end

    foreach (code_exp_addr[k])
      fetch_insn(code_exp_addr[k], code_exp_val[k]);

    // Data words in shuffled order
    foreach (data_exp_addr[k])
      order.push_back(k);
    for (int k = order.size() - 1; k > 0; k--) begin
      j        = int'($urandom_range(k, 0));
      tmp      = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    foreach (order[k])
      read_data_word(data_exp_addr[order[k]], data_exp_val[order[k]]);

    waddr = spif_pkg::data_addr_t'($urandom_range(1023, 0));
    wval  = spif_pkg::data_word_t'($urandom);
    write_data_word(waddr, wval);
    read_data_word(waddr, wval);

    count_is("o_p_hold pulses", hold_pulses, code_exp_addr.size() + data_exp_addr.size());
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: verification/flash_model.sv
// ======================================================================
// Behavioural SPI flash for the loader testbench. Captures the read
// header and streams image bytes in mode 0, one read per run.
// ======================================================================

module flash_model (
  input  logic         i_sclk,
  input  logic         i_cs_n,
  input  logic         i_mosi,
  output logic         o_miso,
  output logic [39:0]  o_hdr,       // Header bytes, first byte on top
  output logic [2:0]   o_hdr_cnt
);

  spif_pkg::byte_t  image [256];    // Loaded by the testbench
  spif_pkg::byte_t  in_sh = 8'h00;
  logic [39:0]      hdr = '0;
  logic [2:0]       hdr_cnt = 3'd0;
  logic             miso = 1'b0;
  int               bit_cnt = 0;    // Rising edges since CS fell

  assign o_miso    = miso;
  assign o_hdr     = hdr;
  assign o_hdr_cnt = hdr_cnt;

  task automatic put_byte(input logic [7:0] idx, input spif_pkg::byte_t b);
    image[idx] = b;
  endtask

  // MOSI sampled on the rising edge
  always @(posedge i_sclk) begin
    if (!i_cs_n) begin
      in_sh   = {in_sh[6:0], i_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt % 8 == 0 && hdr_cnt < 3'd5) begin
        hdr     = {hdr[31:0], in_sh};
        hdr_cnt = hdr_cnt + 3'd1;
      end
    end
  end

  // Next read bit driven on the falling edge, MSB first
  always @(negedge i_sclk) begin
    int pos;
    pos = bit_cnt - 40;
    if (!i_cs_n && pos >= 0) begin
      if (pos < 2048)
        miso <= image[8'(pos / 8)][3'(7 - pos % 8)];
      else
        miso <= 1'b1;               // Past the image
    end
  end

endmodule

// File: src/spif_top.sv
// ======================================================================
// Boot flash loader top. Connects the fetch pipeline, both RAMs and the
// processor memory ports; the SPI pins go straight to the flash.
// ======================================================================

module spif_top (
  input  logic                   clk,
  input  logic                   arstn,
  input  spif_pkg::code_addr_t   i_code_addr,
  output spif_pkg::code_word_t   o_insn,
  input  logic                   i_mem_rd,
  input  logic                   i_mem_wr,
  input  spif_pkg::data_addr_t   i_mem_addr,
  input  spif_pkg::data_word_t   i_din,
  output spif_pkg::data_word_t   o_mem_dout,
  output logic                   o_p_hold,
  output logic                   o_p_reset,
  output logic                   o_booting,
  output logic                   o_sclk,
  output logic                   o_cs_n,
  output logic                   o_mosi,
  input  logic                   i_miso
);

  spi_xfer_if u_xfer ();
  boot_wr_if  u_wr ();

  logic                  byte_stb;
  spif_pkg::byte_t       flash_byte;
  spif_pkg::rate_t       rate;
  logic                  boot_end;
  spif_pkg::code_addr_t  code_addr;
  spif_pkg::code_word_t  code_din;
  logic                  code_we;
  logic                  code_re;
  spif_pkg::data_addr_t  data_addr;
  spif_pkg::data_word_t  data_din;
  logic                  data_we;
  logic                  data_re;

  // ====================================================================
  // Flash pipeline
  // ====================================================================
  spi_byte_master u_spi (
    .clk    (clk),     .arstn  (arstn),   .x      (u_xfer.slave),
    .o_sclk (o_sclk),  .o_cs_n (o_cs_n),  .o_mosi (o_mosi),  .i_miso (i_miso)
  );

  boot_fetch u_fetch (
    .clk        (clk),        .arstn   (arstn),       .x      (u_xfer.master),
    .i_rate     (rate),       .i_end   (boot_end),
    .o_byte_stb (byte_stb),   .o_byte  (flash_byte),  .o_booting (o_booting)
  );

  boot_interp u_interp (
    .clk        (clk),        .arstn     (arstn),
    .i_byte_stb (byte_stb),   .i_byte    (flash_byte),  .w     (u_wr.master),
    .o_rate     (rate),       .o_p_reset (o_p_reset),   .o_end (boot_end)
  );

  // ====================================================================
  // Memory ports and RAMs
  // ====================================================================
  mem_port_mux u_mux (
    .w           (u_wr.slave),  .i_code_addr (i_code_addr),
    .i_mem_rd    (i_mem_rd),    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),  .i_din       (i_din),       .o_p_hold  (o_p_hold),
    .o_code_addr (code_addr),   .o_code_din  (code_din),
    .o_code_we   (code_we),     .o_code_re   (code_re),
    .o_data_addr (data_addr),   .o_data_din  (data_din),
    .o_data_we   (data_we),     .o_data_re   (data_re)
  );

  spram #(.word_t(spif_pkg::code_word_t), .AW(spif_pkg::CODE_AW)) u_code_ram (
    .clk  (clk),      .i_addr (code_addr),  .i_din  (code_din),
    .i_we (code_we),  .i_re   (code_re),    .o_dout (o_insn)
  );

  spram #(.word_t(spif_pkg::data_word_t), .AW(spif_pkg::DATA_AW)) u_data_ram (
    .clk  (clk),      .i_addr (data_addr),  .i_din  (data_din),
    .i_we (data_we),  .i_re   (data_re),    .o_dout (o_mem_dout)
  );

endmodule

// File: src/mem_port_mux.sv
// ======================================================================
// Code and data RAM port selection. Boot writes take the ports and hold
// the processor for that cycle; processor accesses then go unserved.
// ======================================================================

module mem_port_mux (
  boot_wr_if.slave                w,
  input  spif_pkg::code_addr_t    i_code_addr,
  input  logic                    i_mem_rd,
  input  logic                    i_mem_wr,
  input  spif_pkg::data_addr_t    i_mem_addr,
  input  spif_pkg::data_word_t    i_din,
  output logic                    o_p_hold,
  output spif_pkg::code_addr_t    o_code_addr,
  output spif_pkg::code_word_t    o_code_din,
  output logic                    o_code_we,
  output logic                    o_code_re,
  output spif_pkg::data_addr_t    o_data_addr,
  output spif_pkg::data_word_t    o_data_din,
  output logic                    o_data_we,
  output logic                    o_data_re
);

  assign o_p_hold = w.code_we | w.data_we;

  // Code side, written only by boot
  assign o_code_addr = o_p_hold ? w.dest[spif_pkg::CODE_AW-1:0] : i_code_addr;
  assign o_code_din  = w.word[15:0];          // Low 16 bits of the word
  assign o_code_we   = w.code_we;
  assign o_code_re   = ~o_p_hold;

  // Data side, shared with the processor
  assign o_data_addr = o_p_hold ? w.dest[spif_pkg::DATA_AW-1:0] : i_mem_addr;
  assign o_data_din  = o_p_hold ? w.word : i_din;
  assign o_data_we   = w.data_we | (i_mem_wr & ~o_p_hold);
  assign o_data_re   = i_mem_rd & ~o_p_hold;

endmodule

// File: src/spram.sv
// ======================================================================
// Single-port synchronous RAM. The read register only loads while the
// read enable is high; the word type is set per instance.
// ======================================================================

module spram #(
  parameter type word_t = logic [15:0],
  parameter int  AW     = 10
) (
  input  logic           clk,
  input  logic [AW-1:0]  i_addr,
  input  word_t          i_din,
  input  logic           i_we,
  input  logic           i_re,
  output word_t          o_dout
);

  word_t mem [2**AW];

  always_ff @(posedge clk) begin
    if (i_we)
      mem[i_addr] <= i_din;
    if (i_re)
      o_dout <= mem[i_addr];      // Old data on read during write
  end

endmodule

// File: src/boot_interp.sv
// ======================================================================
// Record interpreter. Turns the flash byte stream into rate changes,
// destination and length settings, RAM word writes and end of boot.
// ======================================================================

module boot_interp (
  input  logic              clk,
  input  logic              arstn,
  input  logic              i_byte_stb,
  input  spif_pkg::byte_t   i_byte,
  boot_wr_if.master         w,
  output spif_pkg::rate_t   o_rate,
  output logic              o_p_reset,
  output logic              o_end
);

  typedef enum logic [2:0] {
    M_CMD, M_DATA, M_DEST_H, M_DEST_L, M_LEN_H, M_LEN_L
  } mode_t;

  mode_t                 mode;
  spif_pkg::boot_dest_t  dest;
  spif_pkg::boot_len_t   len;
  spif_pkg::boot_len_t   word_cnt;       // Words left in run, minus one
  logic [1:0]            bpw;            // Bytes per word, minus one
  logic [1:0]            byte_cnt;
  logic                  sel_data;
  spif_pkg::data_word_t  word_sh;

  assign w.dest = dest;
  assign w.word = word_sh;

  // ====================================================================
  // Command decode and run control
  // ====================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      mode      <= M_CMD;
      dest      <= '0;
      len       <= '0;
      word_cnt  <= '0;
      bpw       <= '0;
      byte_cnt  <= '0;
      sel_data  <= 1'b0;
      w.code_we <= 1'b0;
      w.data_we <= 1'b0;
      o_rate    <= spif_pkg::RATE_POR;
      o_p_reset <= 1'b1;
      o_end     <= 1'b0;
    end else begin
      w.code_we <= 1'b0;
      w.data_we <= 1'b0;
      o_end     <= 1'b0;
      if (w.code_we || w.data_we)
        dest <= dest + 16'd1;             // Advance after each word
      if (i_byte_stb) begin
        case (mode)
          M_CMD: begin
            if (i_byte[7:6] == spif_pkg::REC_DATA) begin
              mode     <= M_DATA;
              sel_data <= i_byte[2];
              bpw      <= i_byte[1:0];
              byte_cnt <= i_byte[1:0];
              word_cnt <= len;
            end else if (i_byte[7:6] == spif_pkg::REC_RATE) begin
              o_p_reset <= i_byte[5];
              o_rate    <= i_byte[3:0];
            end else if (i_byte[7:4] == spif_pkg::REC_DEST) begin
              mode <= M_DEST_H;
            end else if (i_byte[7:4] == spif_pkg::REC_LEN) begin
              mode <= M_LEN_H;
            end else if (i_byte[7:5] == spif_pkg::REC_END) begin
              o_end     <= 1'b1;
              o_p_reset <= 1'b0;          // Release the processor
            end
          end
          M_DATA: begin
            if (byte_cnt != 2'd0) begin
              byte_cnt <= byte_cnt - 2'd1;
            end else begin
              byte_cnt  <= bpw;
              w.code_we <= ~sel_data;
              w.data_we <= sel_data;
              if (word_cnt != '0)
                word_cnt <= word_cnt - 16'd1;
              else
                mode <= M_CMD;            // Run complete
            end
          end
          M_DEST_H: begin
            dest[15:8] <= i_byte;
            mode       <= M_DEST_L;
          end
          M_DEST_L: begin
            dest[7:0] <= i_byte;
            mode      <= M_CMD;
          end
          M_LEN_H: begin
            len[15:8] <= i_byte;
            mode      <= M_LEN_L;
          end
          default: begin
            len[7:0] <= i_byte;
            mode     <= M_CMD;
          end
        endcase
      end
    end
  end

  // Word assembly, most significant byte first
  always_ff @(posedge clk) begin
    if (i_byte_stb && mode == M_DATA)
      word_sh <= {word_sh[spif_pkg::DATA_W-9:0], i_byte};
  end

endmodule

// File: src/boot_fetch.sv
// ======================================================================
// Flash fetch sequencer. Sends the fast-read header after reset, then
// streams bytes to the interpreter until the end record arrives.
// ======================================================================

module boot_fetch (
  input  logic              clk,
  input  logic              arstn,
  spi_xfer_if.master        x,
  input  spif_pkg::rate_t   i_rate,
  input  logic              i_end,
  output logic              o_byte_stb,
  output spif_pkg::byte_t   o_byte,
  output logic              o_booting
);

  logic        kick;          // First start pending after reset
  logic        start_q;
  logic [2:0]  hdr_cnt;       // Header bytes already sent
  logic        hdr_done;

  assign hdr_done  = (hdr_cnt == spif_pkg::HDR_BYTES);
  assign x.start   = start_q && !i_end;     // No read past the end record
  assign x.rate    = i_rate;
  assign x.keep_cs = o_booting;

  always_comb begin
    case (hdr_cnt)
      3'd0:    x.tx = spif_pkg::FAST_READ_CMD;
      3'd1:    x.tx = spif_pkg::BASE_BLOCK;
      default: x.tx = '0;                   // Low address, dummy, reads
    endcase
  end

  assign o_byte_stb = x.done && hdr_done && o_booting;
  assign o_byte     = x.rx;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      kick      <= 1'b1;
      start_q   <= 1'b0;
      hdr_cnt   <= '0;
      o_booting <= 1'b1;
    end else begin
      kick    <= 1'b0;
      start_q <= kick || (x.done && o_booting);
      if (x.done && !hdr_done)
        hdr_cnt <= hdr_cnt + 3'd1;
      if (i_end)
        o_booting <= 1'b0;              // Lets CS rise once idle
    end
  end

endmodule

// File: src/spi_byte_master.sv
// ======================================================================
// SPI mode 0 byte engine. A start moves one byte each way, MSB first,
// taking 16 * (rate + 1) cycles from start to done.
// ======================================================================

module spi_byte_master (
  input  logic       clk,
  input  logic       arstn,
  spi_xfer_if.slave  x,
  output logic       o_sclk,
  output logic       o_cs_n,
  output logic       o_mosi,
  input  logic       i_miso
);

  logic             busy;
  spif_pkg::rate_t  rate_q;       // Divisor latched at start
  spif_pkg::rate_t  div_cnt;
  logic [3:0]       half_cnt;     // SCLK edges taken so far
  logic             tick;
  spif_pkg::byte_t  tx_sh;
  spif_pkg::byte_t  rx_sh;

  assign tick   = busy && (div_cnt == '0);
  assign x.done = tick && o_sclk && (half_cnt == 4'd15);  // Last falling edge
  assign x.rx   = rx_sh;
  assign o_mosi = tx_sh[7];

  // ====================================================================
  // Sequencing, SCLK and chip select
  // ====================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      busy     <= 1'b0;
      rate_q   <= spif_pkg::RATE_POR;
      div_cnt  <= '0;
      half_cnt <= '0;
      o_sclk   <= 1'b0;
      o_cs_n   <= 1'b1;
    end else if (!busy) begin
      if (x.start) begin
        busy     <= 1'b1;
        rate_q   <= x.rate;
        div_cnt  <= x.rate;
        half_cnt <= '0;
        o_cs_n   <= 1'b0;
      end else if (!x.keep_cs) begin
        o_cs_n   <= 1'b1;         // Stream closed by fetch
      end
    end else if (tick) begin
      o_sclk   <= ~o_sclk;
      half_cnt <= half_cnt + 4'd1;
      div_cnt  <= rate_q;
      if (x.done) begin
        busy <= 1'b0;
        if (!x.keep_cs)
          o_cs_n <= 1'b1;
      end
    end else begin
      div_cnt <= div_cnt - 4'd1;
    end
  end

  // Transmit and receive shift registers
  always_ff @(posedge clk) begin
    if (!busy && x.start)
      tx_sh <= x.tx;
    else if (tick && o_sclk && !x.done)
      tx_sh <= {tx_sh[6:0], 1'b0};          // Next bit on falling edge
    if (tick && !o_sclk)
      rx_sh <= {rx_sh[6:0], i_miso};        // Sample on rising edge
  end

endmodule

// File: src/boot_wr_if.sv
// ======================================================================
// Boot memory write, from the record interpreter to the port mux
// ======================================================================

interface boot_wr_if;

  logic                  code_we;   // Code RAM write strobe
  logic                  data_we;   // Data RAM write strobe
  spif_pkg::boot_dest_t  dest;      // Target address
  spif_pkg::data_word_t  word;      // Assembled word

  modport master (
    output code_we, data_we, dest, word
  );

  modport slave (
    input  code_we, data_we, dest, word
  );

endinterface

// File: src/spi_xfer_if.sv
// ======================================================================
// One SPI byte transfer request and its result, fetch to byte master
// ======================================================================

interface spi_xfer_if;

  logic               start;      // One-cycle request, only while idle
  spif_pkg::byte_t    tx;         // Byte to shift out
  spif_pkg::rate_t    rate;       // Half-period divisor for this byte
  logic               keep_cs;    // Hold CS low after the byte
  spif_pkg::byte_t    rx;         // Received byte, valid with done
  logic               done;       // One-cycle completion

  modport master (
    output start, tx, rate, keep_cs,
    input  rx, done
  );

  modport slave (
    input  start, tx, rate, keep_cs,
    output rx, done
  );

endinterface

// File: src/spif_pkg.sv
// ======================================================================
// Shared widths, word types and record encodings for the flash loader.
// Every block refers to these by scoped name.
// ======================================================================

package spif_pkg;

  // ====================================================================
  // Widths and word types
  // ====================================================================
  localparam int CODE_AW = 10;                    // Code RAM address bits
  localparam int DATA_AW = 10;                    // Data RAM address bits
  localparam int DATA_W  = 18;                    // Data cell width

  typedef logic [7:0]         byte_t;             // Flash byte
  typedef logic [15:0]        code_word_t;        // Instruction word
  typedef logic [DATA_W-1:0]  data_word_t;        // Data cell
  typedef logic [CODE_AW-1:0] code_addr_t;
  typedef logic [DATA_AW-1:0] data_addr_t;
  typedef logic [15:0]        boot_dest_t;        // Destination register
  typedef logic [15:0]        boot_len_t;         // Word count minus one
  typedef logic [3:0]         rate_t;             // SCLK half-period divisor

  // ====================================================================
  // Flash access
  // ====================================================================
  localparam rate_t      RATE_POR      = 4'd7;    // Divisor after reset
  localparam byte_t      FAST_READ_CMD = 8'h0B;
  localparam byte_t      BASE_BLOCK    = 8'h01;   // First address byte
  localparam logic [2:0] HDR_BYTES     = 3'd5;    // Cmd, 3 address, dummy

  // ====================================================================
  // Record opcodes, matched on the top bits of a command byte
  // ====================================================================
  localparam logic [1:0] REC_DATA = 2'b00;        // Bit 2 data/code, 1:0 bytes-1
  localparam logic [1:0] REC_RATE = 2'b10;        // Bit 5 reset, 3:0 divisor
  localparam logic [3:0] REC_DEST = 4'b1100;      // Two bytes follow, high first
  localparam logic [3:0] REC_LEN  = 4'b1101;      // Two bytes follow, high first
  localparam logic [2:0] REC_END  = 3'b111;       // End of boot

endpackage
